// ==== armPipe_defs.svh ====
`ifndef ARMPIPE_DEFS_SVH
`define ARMPIPE_DEFS_SVH

// Word size of the datapath.
`define DATA_WIDTH 32

// Sixteen architectural registers.
`define REG_ADDR_WIDTH 4

// Data memory size in words.
`define DMEM_DEPTH 64

`endif

// ==== armPipePkg.sv ====
`include "armPipe_defs.svh"

package armPipePkg;

	typedef logic [`DATA_WIDTH-1:0]     word_t;
	typedef logic [`REG_ADDR_WIDTH-1:0] regAddr_t;
	typedef logic [3:0]                 flags_t;   // {N, Z, C, V}.
	typedef logic [3:0]                 cond_t;
	typedef logic [3:0]                 aluCtrl_t;
	typedef logic [1:0]                 fwdSel_t;

	localparam cond_t COND_EQ = 4'h0;
	localparam cond_t COND_NE = 4'h1;
	localparam cond_t COND_CS = 4'h2;
	localparam cond_t COND_CC = 4'h3;
	localparam cond_t COND_MI = 4'h4;
	localparam cond_t COND_PL = 4'h5;
	localparam cond_t COND_VS = 4'h6;
	localparam cond_t COND_VC = 4'h7;
	localparam cond_t COND_HI = 4'h8;
	localparam cond_t COND_LS = 4'h9;
	localparam cond_t COND_GE = 4'hA;
	localparam cond_t COND_LT = 4'hB;
	localparam cond_t COND_GT = 4'hC;
	localparam cond_t COND_LE = 4'hD;
	localparam cond_t COND_AL = 4'hE;

	localparam aluCtrl_t ALU_ADD = 4'h0;
	localparam aluCtrl_t ALU_SUB = 4'h1;
	localparam aluCtrl_t ALU_AND = 4'h2;
	localparam aluCtrl_t ALU_ORR = 4'h3;
	localparam aluCtrl_t ALU_EOR = 4'h4;
	localparam aluCtrl_t ALU_MOV = 4'h5;

	localparam fwdSel_t FWD_REG = 2'b00;
	localparam fwdSel_t FWD_WB  = 2'b01;
	localparam fwdSel_t FWD_MEM = 2'b10;

	typedef struct packed {
		logic     valid;
		logic     regWrite;
		logic     memWrite;
		logic     memToReg;
		logic     branch;
		logic     pcSrc;
		logic     flagWrite;
		logic     aluSrc;
		aluCtrl_t aluCtrl;
		cond_t    cond;
		regAddr_t ra1;
		regAddr_t ra2;
		regAddr_t wa3;
		word_t    rd1;
		word_t    rd2;
		word_t    ext;
	} exIssue_t;

	typedef struct packed {
		logic     valid;
		logic     regWrite;
		logic     memWrite;
		logic     memToReg;
		logic     pcSrc;
		word_t    aluResult;
		word_t    writeData;
		regAddr_t wa3;
	} memStage_t;

	typedef struct packed {
		logic     valid;
		logic     regWrite;
		logic     memToReg;
		logic     pcSrc;
		word_t    aluResult;
		word_t    readData;
		regAddr_t wa3;
	} wbStage_t;

	typedef struct packed {
		logic     valid;
		logic     regWrite;
		logic     pcSrc;
		regAddr_t wa3;
		word_t    result;
	} retire_t;

endpackage

// ==== alu.sv ====
`timescale 1ns/1ps

module alu (
	input  armPipePkg::word_t    a,
	input  armPipePkg::word_t    b,
	input  armPipePkg::aluCtrl_t aluCtrl,
	output armPipePkg::word_t    result,
	output armPipePkg::flags_t   aluFlags
);
	import armPipePkg::*;

	localparam int W   = $bits(word_t);
	localparam int MSB = W - 1;

	logic         isSub;
	logic         arith;
	word_t        bOp;
	logic [W:0]   sumFull;
	word_t        sum;
	logic         carry;
	logic         overflow;

	assign isSub = (aluCtrl == ALU_SUB);
	assign arith = isSub || (aluCtrl == ALU_ADD);

	// Subtract as a + ~b + 1, so C is the ARM not-borrow.
	assign bOp     = isSub ? ~b : b;
	assign sumFull = {1'b0, a} + {1'b0, bOp} + {{W{1'b0}}, isSub};
	assign sum     = sumFull[MSB:0];
	assign carry   = sumFull[W];

	// Same-sign inputs giving an opposite-sign sum.
	assign overflow = (a[MSB] == bOp[MSB]) && (sum[MSB] != a[MSB]);

	always_comb begin
		case (aluCtrl)
			ALU_ADD: result = sum;
			ALU_SUB: result = sum;
			ALU_AND: result = a & b;
			ALU_ORR: result = a | b;
			ALU_EOR: result = a ^ b;
			ALU_MOV: result = b;
			default: result = '0;
		endcase
	end

	assign aluFlags = {result[MSB], (result == '0), arith & carry, arith & overflow};

endmodule

// ==== condUnit.sv ====
`timescale 1ns/1ps

module condUnit (
	input  logic               Clk,
	input  logic               rst,
	input  logic               valid,
	input  armPipePkg::cond_t  cond,
	input  logic               flagWrite,
	input  armPipePkg::flags_t aluFlags,
	output logic               condEx,
	output armPipePkg::flags_t flags
);
	import armPipePkg::*;

	logic n;
	logic z;
	logic c;
	logic v;

	assign {n, z, c, v} = flags;

	always_comb begin
		case (cond)
			COND_EQ: condEx = z;
			COND_NE: condEx = ~z;
			COND_CS: condEx = c;
			COND_CC: condEx = ~c;
			COND_MI: condEx = n;
			COND_PL: condEx = ~n;
			COND_VS: condEx = v;
			COND_VC: condEx = ~v;
			COND_HI: condEx = c & ~z;
			COND_LS: condEx = ~c | z;
			COND_GE: condEx = (n == v);
			COND_LT: condEx = (n != v);
			COND_GT: condEx = ~z & (n == v);
			COND_LE: condEx = z | (n != v);
			COND_AL: condEx = 1'b1;
			default: condEx = 1'b1;    // Unconditional space.
		endcase
	end

	// Only a passing flag-setting instruction touches NZCV.
	always_ff @(posedge Clk) begin
		if (rst) begin
			flags <= '0;
		end else if (valid && condEx && flagWrite) begin
			flags <= aluFlags;
		end
	end

endmodule

// ==== forwardUnit.sv ====
`timescale 1ns/1ps

module forwardUnit (
	input  armPipePkg::regAddr_t ra1,
	input  armPipePkg::regAddr_t ra2,
	input  armPipePkg::regAddr_t wa3M,
	input  logic                 regWriteM,
	input  armPipePkg::regAddr_t wa3W,
	input  logic                 regWriteW,
	output armPipePkg::fwdSel_t  fwdA,
	output armPipePkg::fwdSel_t  fwdB
);
	import armPipePkg::*;

	// Memory stage holds the younger result, so it is tried first.
	function automatic fwdSel_t pickSrc(input regAddr_t ra);
		if (regWriteM && (wa3M == ra)) begin
			pickSrc = FWD_MEM;
		end else if (regWriteW && (wa3W == ra)) begin
			pickSrc = FWD_WB;
		end else begin
			pickSrc = FWD_REG;
		end
	endfunction

	assign fwdA = pickSrc(ra1);
	assign fwdB = pickSrc(ra2);

endmodule

// ==== execute.sv ====
`timescale 1ns/1ps

module execute (
	input  logic                  Clk,
	input  logic                  rst,
	input  armPipePkg::exIssue_t  issue,
	input  armPipePkg::fwdSel_t   fwdA,
	input  armPipePkg::fwdSel_t   fwdB,
	input  armPipePkg::word_t     resultW,
	output armPipePkg::memStage_t memStage,
	output logic                  branchTaken,
	output armPipePkg::word_t     branchTarget
);
	import armPipePkg::*;

	word_t  srcA;
	word_t  writeDataE;
	word_t  srcB;
	word_t  aluResult;
	flags_t aluFlags;
	logic   condEx;
	logic   passE;

	function automatic word_t fwdMux(
		input fwdSel_t sel,
		input word_t   regVal,
		input word_t   memVal,
		input word_t   wbVal
	);
		case (sel)
			FWD_MEM: fwdMux = memVal;
			FWD_WB:  fwdMux = wbVal;
			default: fwdMux = regVal;
		endcase
	endfunction

	assign srcA       = fwdMux(fwdA, issue.rd1, memStage.aluResult, resultW);
	assign writeDataE = fwdMux(fwdB, issue.rd2, memStage.aluResult, resultW);
	assign srcB       = issue.aluSrc ? issue.ext : writeDataE;

	alu i_alu (
		.a        (srcA),
		.b        (srcB),
		.aluCtrl  (issue.aluCtrl),
		.result   (aluResult),
		.aluFlags (aluFlags)
	);

	condUnit i_condUnit (
		.Clk       (Clk),
		.rst       (rst),
		.valid     (issue.valid),
		.cond      (issue.cond),
		.flagWrite (issue.flagWrite),
		.aluFlags  (aluFlags),
		.condEx    (condEx),
		.flags     ()
	);

	assign passE = issue.valid && condEx;

	assign branchTaken  = issue.branch && passE;
	assign branchTarget = aluResult;    // Target comes out of the ALU.

	always_ff @(posedge Clk) begin
		memStage.memToReg  <= issue.memToReg;
		memStage.aluResult <= aluResult;
		memStage.writeData <= writeDataE;    // Forwarded rd2 is the store data.
		memStage.wa3       <= issue.wa3;
		if (rst) begin
			memStage.valid    <= 1'b0;
			memStage.regWrite <= 1'b0;
			memStage.memWrite <= 1'b0;
			memStage.pcSrc    <= 1'b0;
		end else begin
			memStage.valid    <= issue.valid;
			memStage.regWrite <= issue.regWrite && passE;
			memStage.memWrite <= issue.memWrite && passE;
			memStage.pcSrc    <= issue.pcSrc && passE;
		end
	end

endmodule

// ==== memWriteback.sv ====
`timescale 1ns/1ps

`include "armPipe_defs.svh"

module memWriteback (
	input  logic                  Clk,
	input  logic                  rst,
	input  armPipePkg::memStage_t memStage,
	output armPipePkg::retire_t   retire
);
	import armPipePkg::*;

	localparam int ADDR_W = $clog2(`DMEM_DEPTH);

	word_t             dmem [`DMEM_DEPTH];
	logic [ADDR_W-1:0] wordIdx;
	word_t             readData;
	wbStage_t          wbStage;

	assign wordIdx  = memStage.aluResult[ADDR_W+1:2];    // Word index without the byte offset.
	assign readData = dmem[wordIdx];

	always_ff @(posedge Clk) begin
		if (memStage.memWrite) begin
			dmem[wordIdx] <= memStage.writeData;
		end
	end

	always_ff @(posedge Clk) begin
		wbStage.memToReg  <= memStage.memToReg;
		wbStage.pcSrc     <= memStage.pcSrc;
		wbStage.aluResult <= memStage.aluResult;
		wbStage.readData  <= readData;
		wbStage.wa3       <= memStage.wa3;
		if (rst) begin
			wbStage.valid    <= 1'b0;
			wbStage.regWrite <= 1'b0;
		end else begin
			wbStage.valid    <= memStage.valid;
			wbStage.regWrite <= memStage.regWrite;
		end
	end

	// Retire record doubles as the writeback forward source.
	always_comb begin
		retire.valid    = wbStage.valid;
		retire.regWrite = wbStage.regWrite;
		retire.pcSrc    = wbStage.pcSrc;
		retire.wa3      = wbStage.wa3;
		retire.result   = wbStage.memToReg ? wbStage.readData : wbStage.aluResult;
	end

endmodule

// ==== armExecTop.sv ====
`timescale 1ns/1ps

module armExecTop (
	input  logic                 Clk,
	input  logic                 rst,
	input  armPipePkg::exIssue_t issue,
	output armPipePkg::retire_t  retire,
	output logic                 branchTaken,
	output armPipePkg::word_t    branchTarget
);
	import armPipePkg::*;

	memStage_t memStage;
	fwdSel_t   fwdA;
	fwdSel_t   fwdB;

	forwardUnit i_forwardUnit (
		.ra1       (issue.ra1),
		.ra2       (issue.ra2),
		.wa3M      (memStage.wa3),
		.regWriteM (memStage.regWrite),
		.wa3W      (retire.wa3),
		.regWriteW (retire.regWrite),
		.fwdA      (fwdA),
		.fwdB      (fwdB)
	);

	execute i_execute (
		.Clk          (Clk),
		.rst          (rst),
		.issue        (issue),
		.fwdA         (fwdA),
		.fwdB         (fwdB),
		.resultW      (retire.result),
		.memStage     (memStage),
		.branchTaken  (branchTaken),
		.branchTarget (branchTarget)
	);

	memWriteback i_memWriteback (
		.Clk      (Clk),
		.rst      (rst),
		.memStage (memStage),
		.retire   (retire)
	);

endmodule

// ==== tbChecker.sv ====
`timescale 1ns/1ps

module tbChecker (
	input  logic                Clk,
	input  logic                rst,
	input  armPipePkg::retire_t retire,
	input  logic                branchTaken,
	input  armPipePkg::word_t   branchTarget,
	input  logic                expPush,
	input  armPipePkg::retire_t expRetire,
	input  logic                expBranch,
	input  armPipePkg::word_t   expTarget,
	input  int                  testId,
	input  logic                testEnd,
	input  logic                allDone,
	output int                  pending,
	output int                  errCount
);
	import armPipePkg::*;

	retire_t expQ [$];
	int      dueQ [$];    // Cycle each queued result must retire in.
	retire_t exp;
	int      due;
	int      cycle = 0;
	int      qSize = 0;
	int      errs = 0;
	int      testErrs = 0;
	int      passTests = 0;
	int      failTests = 0;

	assign pending  = qSize;
	assign errCount = errs;

	function automatic string testName(input int id);
		case (id)
			1: testName = "reset";
			2: testName = "ALU operations";
			3: testName = "forwarding";
			4: testName = "conditional execution";
			5: testName = "loads and stores";
			6: testName = "branches";
			default: testName = "unknown";
		endcase
	endfunction

	task automatic reportMismatch(input string name, input word_t expVal, input word_t gotVal);
		$display("MISMATCH %s exp=%h got=%h", name, expVal, gotVal);
		testErrs++;
		errs++;
	endtask

	task automatic reportError(input string msg);
		$display("ERROR: %s", msg);
		testErrs++;
		errs++;
	endtask

	// Sampled mid-cycle away from the edges.
	always @(negedge Clk) begin
		if (rst && (retire.valid !== 1'b0 || branchTaken !== 1'b0)) begin
			reportError("retire valid or branchTaken raised during reset");
		end
		if (branchTaken !== expBranch) begin
			reportMismatch("branchTaken", word_t'(expBranch), word_t'(branchTaken));
		end else if (expBranch && branchTarget !== expTarget) begin
			reportMismatch("branchTarget", expTarget, branchTarget);
		end
		if (retire.valid === 1'b1) begin
			if (expQ.size() == 0) begin
				reportError("retire valid with no instruction outstanding");
			end else begin
				exp = expQ.pop_front();
				due = dueQ.pop_front();
				if (due != cycle)
					reportError("retire did not arrive two cycles after its issue");
				if (retire.regWrite !== exp.regWrite)
					reportMismatch("retire.regWrite", word_t'(exp.regWrite), word_t'(retire.regWrite));
				if (retire.pcSrc !== exp.pcSrc)
					reportMismatch("retire.pcSrc", word_t'(exp.pcSrc), word_t'(retire.pcSrc));
				if (retire.wa3 !== exp.wa3)
					reportMismatch("retire.wa3", word_t'(exp.wa3), word_t'(retire.wa3));
				if (retire.result !== exp.result)
					reportMismatch("retire.result", exp.result, retire.result);
			end
		end
		if (expPush) begin
			expQ.push_back(expRetire);
			dueQ.push_back(cycle + 2);
		end
		if (testEnd) begin
			if (expQ.size() != 0) begin
				reportError($sformatf("%0d issued instructions never retired", expQ.size()));
				expQ.delete();
				dueQ.delete();
			end
			$display("Test %0d %s: %s (%0d errors)", testId, testName(testId),
				testErrs == 0 ? "pass" : "fail", testErrs);
			if (testErrs == 0) passTests++;
			else failTests++;
			testErrs = 0;
		end
		qSize = expQ.size();
		cycle++;
		if (allDone) begin
			$display("Summary: %0d tests passed, %0d tests failed, %0d errors",
				passTests, failTests, errs);
		end
	end

endmodule

// ==== tbArmExec.sv ====
`timescale 1ns/1ps

`include "armPipe_defs.svh"

module tbArmExec;
	import armPipePkg::*;

	logic     Clk;
	logic     rst;
	exIssue_t issue;
	retire_t  retire;
	logic     branchTaken;
	word_t    branchTarget;
	logic     expPush;
	retire_t  expRetire;
	logic     expBranch;
	word_t    expTarget;
	int       testId;
	logic     testEnd;
	logic     allDone;
	int       pending;
	int       errCount;

	integer   seed = 32'had6ee384;
	word_t    curReg [16];     // Architectural registers.
	word_t    fileReg [16];    // Register file view lagging two issues.
	flags_t   mFlags;
	word_t    mMem [`DMEM_DEPTH];
	logic     pendW [2];
	regAddr_t pendA [2];
	word_t    pendV [2];

	initial Clk = 1'b0;
	always #20 Clk = ~Clk;

	armExecTop i_dut (
		.Clk          (Clk),
		.rst          (rst),
		.issue        (issue),
		.retire       (retire),
		.branchTaken  (branchTaken),
		.branchTarget (branchTarget)
	);

	tbChecker i_checker (
		.Clk          (Clk),
		.rst          (rst),
		.retire       (retire),
		.branchTaken  (branchTaken),
		.branchTarget (branchTarget),
		.expPush      (expPush),
		.expRetire    (expRetire),
		.expBranch    (expBranch),
		.expTarget    (expTarget),
		.testId       (testId),
		.testEnd      (testEnd),
		.allDone      (allDone),
		.pending      (pending),
		.errCount     (errCount)
	);

	function automatic int unsigned rnd(input int unsigned n);
		rnd = $unsigned($random(seed)) % n;
	endfunction

	// Flags are {N, Z, C, V}.
	function automatic logic condPass(input cond_t c, input flags_t f);
		case (c)
			COND_EQ: condPass = f[2];
			COND_NE: condPass = !f[2];
			COND_CS: condPass = f[1];
			COND_CC: condPass = !f[1];
			COND_MI: condPass = f[3];
			COND_PL: condPass = !f[3];
			COND_VS: condPass = f[0];
			COND_VC: condPass = !f[0];
			COND_HI: condPass = f[1] && !f[2];
			COND_LS: condPass = !f[1] || f[2];
			COND_GE: condPass = f[3] == f[0];
			COND_LT: condPass = f[3] != f[0];
			COND_GT: condPass = !f[2] && (f[3] == f[0]);
			COND_LE: condPass = f[2] || (f[3] != f[0]);
			default: condPass = 1'b1;
		endcase
	endfunction

	function automatic word_t aluRef(input aluCtrl_t op, input word_t a, input word_t b,
		output flags_t f);
		logic [32:0] wide;
		word_t       r;
		logic        c;
		logic        v;
		c = 1'b0;
		v = 1'b0;
		case (op)
			ALU_ADD: begin
				wide = {1'b0, a} + {1'b0, b};
				r = wide[31:0];
				c = wide[32];
				v = (a[31] == b[31]) && (r[31] != a[31]);
			end
			ALU_SUB: begin
				r = a - b;
				c = (a >= b);    // Carry set when no borrow.
				v = (a[31] != b[31]) && (r[31] != a[31]);
			end
			ALU_AND: r = a & b;
			ALU_ORR: r = a | b;
			ALU_EOR: r = a ^ b;
			default: r = b;
		endcase
		f = {r[31], (r == 32'h0), c, v};
		aluRef = r;
	endfunction

	// Executes one instruction on the architectural state.
	function automatic retire_t refModel(input exIssue_t ins, output logic brTaken,
		output word_t brTarget);
		retire_t exp;
		word_t   b;
		word_t   res;
		flags_t  f;
		logic    pass;
		b = curReg[ins.ra2];
		res = aluRef(ins.aluCtrl, curReg[ins.ra1], ins.aluSrc ? ins.ext : b, f);
		pass = condPass(ins.cond, mFlags);
		exp.valid = 1'b1;
		exp.regWrite = ins.regWrite && pass;
		exp.pcSrc = ins.pcSrc && pass;
		exp.wa3 = ins.wa3;
		exp.result = res;
		if (pass && ins.memWrite) mMem[res[7:2]] = b;    // Word index into 64 words.
		if (ins.memToReg) exp.result = mMem[res[7:2]];
		if (pass && ins.flagWrite) mFlags = f;
		if (exp.regWrite) curReg[ins.wa3] = exp.result;
		brTaken = ins.branch && pass;
		brTarget = res;
		refModel = exp;
	endfunction

	task automatic drive(input exIssue_t ins);
		retire_t exp;
		logic    brT;
		word_t   brTgt;
		exp = '0;
		brT = 1'b0;
		brTgt = '0;
		@(posedge Clk);
		#2;
		ins.rd1 = fileReg[ins.ra1];    // Possibly stale.
		ins.rd2 = fileReg[ins.ra2];
		if (ins.valid) exp = refModel(ins, brT, brTgt);
		if (pendW[0]) fileReg[pendA[0]] = pendV[0];
		pendW[0] = pendW[1];
		pendA[0] = pendA[1];
		pendV[0] = pendV[1];
		pendW[1] = ins.valid && exp.regWrite;
		pendA[1] = ins.wa3;
		pendV[1] = exp.result;
		expPush = ins.valid;
		expRetire = exp;
		expBranch = brT;
		expTarget = brTgt;
		issue = ins;
	endtask

	function automatic exIssue_t mkOp(input aluCtrl_t op, input cond_t c, input regAddr_t ra1,
		input regAddr_t ra2, input regAddr_t wa3, input logic aluSrc, input word_t ext);
		exIssue_t i;
		i = '0;
		i.valid = 1'b1;
		i.regWrite = 1'b1;
		i.aluCtrl = op;
		i.cond = c;
		i.ra1 = ra1;
		i.ra2 = ra2;
		i.wa3 = wa3;
		i.aluSrc = aluSrc;
		i.ext = ext;
		mkOp = i;
	endfunction

	function automatic exIssue_t randOp(input cond_t c);
		randOp = mkOp(aluCtrl_t'(rnd(6)), c, regAddr_t'(rnd(16)), regAddr_t'(rnd(16)),
			regAddr_t'(rnd(16)), rnd(2) == 1, $random(seed));
		randOp.flagWrite = rnd(2) == 1;
	endfunction

	// Compare that sets NZCV and writes no register.
	function automatic exIssue_t cmpOp(input regAddr_t ra1, input regAddr_t ra2);
		cmpOp = mkOp(ALU_SUB, COND_AL, ra1, ra2, 4'd0, 1'b0, 32'h0);
		cmpOp.regWrite = 1'b0;
		cmpOp.flagWrite = 1'b1;
	endfunction

	task automatic finishTest(input int id);
		int waited;
		waited = 0;
		drive('0);
		while (pending != 0 && waited < 20) begin
			drive('0);
			waited++;
		end
		testId = id;
		testEnd = 1'b1;
		drive('0);
		testEnd = 1'b0;
	endtask

	initial begin
		exIssue_t ins;
		regAddr_t near0;
		regAddr_t near1;
		issue = '0;
		rst = 1'b1;
		expPush = 1'b0;
		expRetire = '0;
		expBranch = 1'b0;
		expTarget = '0;
		testId = 0;
		testEnd = 1'b0;
		allDone = 1'b0;
		mFlags = '0;
		near0 = '0;
		near1 = '0;
		for (int r = 0; r < 16; r++) begin
			curReg[r] = '0;
			fileReg[r] = '0;
		end
		for (int p = 0; p < 2; p++) begin
			pendW[p] = 1'b0;
			pendA[p] = '0;
			pendV[p] = '0;
		end

		// Invalid branches during reset must not reach branchTaken.
		for (int c = 0; c < 16; c++) begin
			ins = randOp(COND_AL);
			ins.valid = 1'b0;
			ins.branch = 1'b1;
			drive(ins);
		end
		rst = 1'b0;
		drive(ins);
		drive(mkOp(ALU_MOV, COND_EQ, 4'd0, 4'd0, 4'd1, 1'b1, 32'h11));
		drive(mkOp(ALU_MOV, COND_PL, 4'd0, 4'd0, 4'd2, 1'b1, 32'h22));
		drive(mkOp(ALU_MOV, COND_HI, 4'd0, 4'd0, 4'd3, 1'b1, 32'h33));
		drive(mkOp(ALU_MOV, COND_GE, 4'd0, 4'd0, 4'd4, 1'b1, 32'h44));
		finishTest(1);

		for (int r = 0; r < 16; r++)
			drive(mkOp(ALU_MOV, COND_AL, 4'd0, 4'd0, regAddr_t'(r), 1'b1, $random(seed)));
		for (int k = 0; k < 40; k++) begin
			drive(randOp(COND_AL));
			drive('0);
			drive('0);
		end
		finishTest(2);

		for (int k = 0; k < 40; k++) begin
			ins = randOp(COND_AL);
			ins.aluSrc = rnd(4) == 0;
			ins.ra1 = (rnd(2) == 1) ? near0 : near1;
			ins.ra2 = (ins.ra1 == near0) ? near1 : near0;
			drive(ins);
			near1 = near0;
			near0 = ins.wa3;
		end
		finishTest(3);

		for (int k = 0; k < 30; k++) begin
			near0 = regAddr_t'(rnd(16));
			drive(cmpOp(near0, (k < 15) ? near0 : regAddr_t'(rnd(16))));
			drive(randOp(cond_t'(k % 15)));
			drive(randOp(cond_t'(rnd(15))));    // Sees the flags left by the previous op.
		end
		finishTest(4);

		drive(mkOp(ALU_MOV, COND_AL, 4'd0, 4'd0, 4'd0, 1'b1, 32'h0));    // Base register.
		for (int k = 0; k < 8; k++) begin
			ins = mkOp(ALU_ADD, COND_AL, 4'd0, regAddr_t'(rnd(16)), 4'd0, 1'b1, word_t'(k * 20));
			ins.regWrite = 1'b0;
			ins.memWrite = 1'b1;
			drive(ins);
			if (k % 2 == 0) begin
				ins.memWrite = 1'b0;
				ins.memToReg = 1'b1;
				ins.regWrite = 1'b1;
				ins.wa3 = regAddr_t'(1 + rnd(15));
				drive(ins);
				drive('0);
			end
		end
		for (int k = 0; k < 8; k++) begin
			ins = mkOp(ALU_ADD, COND_AL, 4'd0, 4'd0, regAddr_t'(1 + rnd(15)), 1'b1,
				word_t'(((k * 3) % 8) * 20));
			ins.memToReg = 1'b1;
			drive(ins);
			drive('0);    // Load destination unread next cycle.
		end
		// Store data that differs from the word at address 0.
		drive(mkOp(ALU_MOV, COND_AL, 4'd0, 4'd0, 4'd6, 1'b1, ~mMem[0]));
		drive(cmpOp(4'd0, 4'd0));
		ins = mkOp(ALU_ADD, COND_NE, 4'd0, 4'd6, 4'd0, 1'b1, 32'h0);
		ins.regWrite = 1'b0;
		ins.memWrite = 1'b1;
		drive(ins);
		ins = mkOp(ALU_ADD, COND_AL, 4'd0, 4'd0, 4'd5, 1'b1, 32'h0);
		ins.memToReg = 1'b1;
		drive(ins);
		finishTest(5);

		for (int k = 0; k < 24; k++) begin
			near0 = regAddr_t'(rnd(16));
			drive(cmpOp(near0, (k % 3 == 0) ? near0 : regAddr_t'(rnd(16))));
			ins = mkOp(ALU_ADD, cond_t'(rnd(15)), regAddr_t'(rnd(16)), 4'd0, 4'd0, 1'b1,
				$random(seed));
			ins.regWrite = 1'b0;
			ins.branch = 1'b1;
			ins.pcSrc = 1'b1;
			drive(ins);
		end
		finishTest(6);

		allDone = 1'b1;
		drive('0);
		if (errCount == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+.
armPipePkg.sv
alu.sv
condUnit.sv
forwardUnit.sv
execute.sv
memWriteback.sv
armExecTop.sv
tbChecker.sv
tbArmExec.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --top-module tbArmExec -f compile.f -Mdir obj_dir -o simArmExec
	@out="$$(./obj_dir/simArmExec)"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
